// File: arcade_dl_pkg.sv
`default_nettype none

package arcade_dl_pkg;

	// ==================================================
	// Loader bus widths
	// ==================================================

	// Host loader address and data
	localparam int DL_ADDR_W = 25;
	localparam int DL_DATA_W = 8;

	// Sound CPU address space, 64 KiB
	localparam int SND_ADDR_W = 16;

	typedef logic [DL_ADDR_W-1:0]  dl_addr_t;
	typedef logic [DL_DATA_W-1:0]  dl_byte_t;
	typedef logic [SND_ADDR_W-1:0] snd_addr_t;

	// ==================================================
	// Download regions
	// ==================================================

	// Destination of one decoded loader write
	typedef enum logic [2:0] {
		REGION_NONE,
		REGION_CPU,
		REGION_SND,
		REGION_GFX,
		REGION_DIP,
		REGION_VARIANT
	} dl_region_e;

	// Loader index codes
	localparam dl_byte_t ROM_INDEX     = 8'd0;
	localparam dl_byte_t VARIANT_INDEX = 8'd1;
	localparam dl_byte_t DIP_INDEX     = 8'd254;

	// ROM image layout, CPU code sits below SND_BASE
	localparam dl_addr_t SND_BASE = 25'h20000;
	localparam dl_addr_t GFX_BASE = 25'h30000;

	// Only the first two switch banks reach the core
	localparam int DIP_COUNT = 2;

	// Hardware variant codes of the portrait games
	localparam dl_byte_t VARIANT_PORTRAIT     = 8'h06;
	// Portrait and turned the other way
	localparam dl_byte_t VARIANT_PORTRAIT_CCW = 8'h0B;

	// ==================================================
	// Core reset stretch
	// ==================================================

	// Cycles of core reset after the last cause goes away
	localparam int RESET_HOLD_CYCLES = 64;
	localparam int HOLD_CNT_W        = $clog2(RESET_HOLD_CYCLES + 1);

endpackage

`default_nettype wire

// File: dl_cmd_if.sv
`default_nettype none

// One decoded loader write, plus the ROM download level
interface dl_cmd_if import arcade_dl_pkg::*; ();

	// Single cycle write strobe
	logic       wr;
	// Where the byte goes, never NONE while wr is high
	dl_region_e region;
	// Address relative to the region base
	dl_addr_t   offset;
	dl_byte_t   data;
	// High while the ROM image is downloading
	logic       rom_active;

	// Decoder side
	modport src (
		output wr,
		output region,
		output offset,
		output data,
		output rom_active
	);

	// Download store side
	modport sink (
		input wr,
		input region,
		input offset,
		input data
	);

	// Reset sequencer only watches the download level
	modport mon (
		input rom_active
	);

endinterface

`default_nettype wire

// File: dl_decoder.sv
`default_nettype none

module dl_decoder import arcade_dl_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     ioctl_download,
	input  logic     ioctl_wr,
	input  dl_byte_t ioctl_index,
	input  dl_addr_t ioctl_addr,
	input  dl_byte_t ioctl_dout,
	dl_cmd_if.src    cmd
);

	// ==================================================
	// Input stage
	// ==================================================

	// Previous ioctl_wr for the rising edge test
	logic wr_last;
	// Rising edge seen on the last sampled write
	logic wr_seen;

	// Loader payload held for the decode stage
	dl_byte_t index_q;
	dl_addr_t addr_q;
	dl_byte_t dout_q;

	// Decode result of the held payload
	dl_region_e region_c;
	dl_addr_t   base_c;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_last        <= 1'b0;
			wr_seen        <= 1'b0;
			cmd.rom_active <= 1'b0;
		end else begin
			wr_last <= ioctl_wr;
			// One pulse per loader write, however long ioctl_wr stays up
			wr_seen <= ioctl_wr & ~wr_last;
			// ROM download level, same stage as the payload
			cmd.rom_active <= ioctl_download && (ioctl_index == ROM_INDEX);
		end
	end

	always_ff @(posedge clk_sys) begin
		index_q <= ioctl_index;
		addr_q  <= ioctl_addr;
		dout_q  <= ioctl_dout;
	end

	// ==================================================
	// Region decode
	// ==================================================

	always_comb begin
		region_c = REGION_NONE;
		base_c   = '0;
		if (cmd.rom_active) begin
			// ROM image split by address
			if (addr_q < SND_BASE) begin
				region_c = REGION_CPU;
			end else if (addr_q < GFX_BASE) begin
				region_c = REGION_SND;
				base_c   = SND_BASE;
			end else begin
				region_c = REGION_GFX;
				base_c   = GFX_BASE;
			end
		end else if (index_q == VARIANT_INDEX) begin
			region_c = REGION_VARIANT;
		end else if ((index_q == DIP_INDEX) && (addr_q < dl_addr_t'(DIP_COUNT))) begin
			// Higher switch banks are ignored
			region_c = REGION_DIP;
		end
	end

	// Output stage, writes to no region are dropped here
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd.wr <= 1'b0;
		end else begin
			cmd.wr <= wr_seen && (region_c != REGION_NONE);
		end
	end

	always_ff @(posedge clk_sys) begin
		cmd.region <= region_c;
		cmd.offset <= addr_q - base_c;
		cmd.data   <= dout_q;
	end

	// Store counts each strobe as one byte
	a_wr_single : assert property (
		@(posedge clk_sys) disable iff (reset) cmd.wr |=> !cmd.wr
	) else $error("dl_decoder: wr held high for two cycles");

endmodule

`default_nettype wire

// File: dl_store.sv
`default_nettype none

module dl_store import arcade_dl_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	dl_cmd_if.sink    cmd,
	input  snd_addr_t snd_rom_addr,
	output dl_byte_t  snd_rom_data,
	output dl_byte_t  dip_sw0,
	output dl_byte_t  dip_sw1,
	output dl_byte_t  hw_variant,
	output logic      landscape,
	output logic      rotate_ccw,
	output logic      port1_req,
	output logic      port2_req
);

	// ==================================================
	// Sound program ROM
	// ==================================================

	// 64 KiB, loaded once, read by the sound CPU
	dl_byte_t snd_rom [2**SND_ADDR_W];

	// Write strobes per destination
	logic snd_we;
	logic dip_we;
	logic var_we;
	logic sdram_we;

	assign snd_we = cmd.wr && (cmd.region == REGION_SND);
	assign dip_we = cmd.wr && (cmd.region == REGION_DIP);
	assign var_we = cmd.wr && (cmd.region == REGION_VARIANT);
	// Whole ROM image is mirrored to SDRAM, sound part included
	assign sdram_we = cmd.wr && ((cmd.region == REGION_CPU) ||
		(cmd.region == REGION_SND) || (cmd.region == REGION_GFX));

	// Offset stays below 64 KiB inside the sound region
	always_ff @(posedge clk_sys) begin
		if (snd_we) begin
			snd_rom[cmd.offset[SND_ADDR_W-1:0]] <= cmd.data;
		end
	end

	// Registered read port, one cycle latency
	always_ff @(posedge clk_sys) begin
		snd_rom_data <= snd_rom[snd_rom_addr];
	end

	// ==================================================
	// Configuration bytes
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dip_sw0    <= '0;
			dip_sw1    <= '0;
			hw_variant <= '0;
		end else begin
			// Decoder only passes bank 0 and 1
			if (dip_we && (cmd.offset == dl_addr_t'(0))) begin
				dip_sw0 <= cmd.data;
			end
			if (dip_we && (cmd.offset == dl_addr_t'(1))) begin
				dip_sw1 <= cmd.data;
			end
			if (var_we) begin
				hw_variant <= cmd.data;
			end
		end
	end

	// Screen orientation from the variant code
	always_comb begin
		landscape  = 1'b1;
		rotate_ccw = 1'b0;
		case (hw_variant)
			VARIANT_PORTRAIT: begin
				landscape = 1'b0;
			end
			VARIANT_PORTRAIT_CCW: begin
				landscape  = 1'b0;
				rotate_ccw = 1'b1;
			end
			default: begin
				// all other games are landscape
			end
		endcase
	end

	// ==================================================
	// SDRAM request toggles
	// ==================================================

	// Each flip asks the SDRAM side to take one byte
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port1_req <= 1'b0;
			port2_req <= 1'b0;
		end else begin
			if (sdram_we) begin
				port1_req <= ~port1_req;
			end
			// Graphics port also gets its own copy
			if (cmd.wr && (cmd.region == REGION_GFX)) begin
				port2_req <= ~port2_req;
			end
		end
	end

	// Decoder must filter unmapped writes
	a_region_valid : assert property (
		@(posedge clk_sys) disable iff (reset) cmd.wr |-> (cmd.region != REGION_NONE)
	) else $error("dl_store: write strobe without a region");

endmodule

`default_nettype wire

// File: core_reset_seq.sv
`default_nettype none

module core_reset_seq import arcade_dl_pkg::*; (
	input  logic  clk_sys,
	input  logic  reset,
	input  logic  soft_reset,
	dl_cmd_if.mon cmd,
	output logic  rom_loaded,
	output logic  core_reset
);

	// ==================================================
	// ROM completion
	// ==================================================

	// Delayed download level for the falling edge
	logic rom_active_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_active_d <= 1'b0;
			rom_loaded   <= 1'b0;
		end else begin
			rom_active_d <= cmd.rom_active;
			// Sticky until the next hard reset
			if (rom_active_d && !cmd.rom_active) begin
				rom_loaded <= 1'b1;
			end
		end
	end

	// ==================================================
	// Reset stretch
	// ==================================================

	// Remaining hold cycles
	logic [HOLD_CNT_W-1:0] hold_cnt;
	// Any reason to keep the core stopped
	logic                  cause;

	assign cause = reset || soft_reset || !rom_loaded;

	always_ff @(posedge clk_sys) begin
		if (cause) begin
			// Reload for as long as a cause is present
			hold_cnt <= HOLD_CNT_W'(RESET_HOLD_CYCLES);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// Registered so the core sees a clean level
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			core_reset <= 1'b1;
		end else begin
			core_reset <= (hold_cnt != '0);
		end
	end

	// Core must never run on a half loaded ROM
	a_reset_until_loaded : assert property (
		@(posedge clk_sys) disable iff (reset) !rom_loaded |-> core_reset
	) else $error("core_reset_seq: core released before ROM load");

endmodule

`default_nettype wire

// File: irem_dl_top.sv
`default_nettype none

module irem_dl_top import arcade_dl_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,

	// Host loader
	input  logic      ioctl_download,
	input  logic      ioctl_wr,
	input  dl_byte_t  ioctl_index,
	input  dl_addr_t  ioctl_addr,
	input  dl_byte_t  ioctl_dout,

	// OSD reset request
	input  logic      soft_reset,

	// Sound CPU ROM port
	input  snd_addr_t snd_rom_addr,
	output dl_byte_t  snd_rom_data,

	// Configuration to the core
	output dl_byte_t  dip_sw0,
	output dl_byte_t  dip_sw1,
	output dl_byte_t  hw_variant,
	output logic      landscape,
	output logic      rotate_ccw,

	// SDRAM write requests, toggle per byte
	output logic      port1_req,
	output logic      port2_req,

	output logic      rom_loaded,
	output logic      core_reset
);

	// Decoded write bus
	dl_cmd_if u_cmd ();

	// ==================================================
	// Download path
	// ==================================================

	dl_decoder u_dl_decoder (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.cmd            (u_cmd.src)
	);

	dl_store u_dl_store (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cmd          (u_cmd.sink),
		.snd_rom_addr (snd_rom_addr),
		.snd_rom_data (snd_rom_data),
		.dip_sw0      (dip_sw0),
		.dip_sw1      (dip_sw1),
		.hw_variant   (hw_variant),
		.landscape    (landscape),
		.rotate_ccw   (rotate_ccw),
		.port1_req    (port1_req),
		.port2_req    (port2_req)
	);

	// Core held in reset until ROM is in place
	core_reset_seq u_core_reset_seq (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.soft_reset (soft_reset),
		.cmd        (u_cmd.mon),
		.rom_loaded (rom_loaded),
		.core_reset (core_reset)
	);

endmodule

`default_nettype wire

// File: tb_irem_dl.sv
`default_nettype none

module tb_irem_dl import arcade_dl_pkg::*; ();

	// Cycle limit of each wait loop
	localparam int WAIT_LIMIT = 8;
	// ROM level reaches rom_loaded through two register stages
	localparam int LOAD_LAG = 2;

	logic      clk_sys;
	logic      reset;
	logic      ioctl_download;
	logic      ioctl_wr;
	dl_byte_t  ioctl_index;
	dl_addr_t  ioctl_addr;
	dl_byte_t  ioctl_dout;
	logic      soft_reset;
	snd_addr_t snd_rom_addr;
	dl_byte_t  snd_rom_data;
	dl_byte_t  dip_sw0;
	dl_byte_t  dip_sw1;
	dl_byte_t  hw_variant;
	logic      landscape;
	logic      rotate_ccw;
	logic      port1_req;
	logic      port2_req;
	logic      rom_loaded;
	logic      core_reset;

	// ==================================================
	// Reference model state
	// ==================================================

	dl_byte_t  snd_model [2**SND_ADDR_W];
	snd_addr_t written_q [$];
	dl_byte_t  dip0_m;
	dl_byte_t  dip1_m;
	dl_byte_t  variant_m;
	// Expected request toggle levels
	logic      p1_par;
	logic      p2_par;
	logic [31:0] rng_state;

	irem_dl_top u_irem_dl_top (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.soft_reset     (soft_reset),
		.snd_rom_addr   (snd_rom_addr),
		.snd_rom_data   (snd_rom_data),
		.dip_sw0        (dip_sw0),
		.dip_sw1        (dip_sw1),
		.hw_variant     (hw_variant),
		.landscape      (landscape),
		.rotate_ccw     (rotate_ccw),
		.port1_req      (port1_req),
		.port2_req      (port2_req),
		.rom_loaded     (rom_loaded),
		.core_reset     (core_reset)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Helpers
	// ==================================================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_byte(input string name, input dl_byte_t exp, input dl_byte_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %s: expected %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input snd_addr_t exp, input snd_addr_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	// Starts on a falling edge and returns two falling edges later
	task automatic loader_write(input dl_byte_t index, input dl_addr_t addr, input dl_byte_t data);
		ioctl_index = index;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		ioctl_wr    = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		@(negedge clk_sys);
	endtask

	// One ROM byte with the model updated from the address map
	task automatic rom_write(input dl_addr_t addr, input dl_byte_t data);
		int        n;
		snd_addr_t off;
		loader_write(ROM_INDEX, addr, data);
		p1_par = ~p1_par;
		if (addr >= GFX_BASE) begin
			p2_par = ~p2_par;
		end else if (addr >= SND_BASE) begin
			off = snd_addr_t'(addr - SND_BASE);
			// Decoded strobe should already be up
			for (n = 0; (n < WAIT_LIMIT) && (u_irem_dl_top.u_cmd.wr !== 1'b1); n++) begin
				@(negedge clk_sys);
			end
			if (u_irem_dl_top.u_cmd.wr !== 1'b1) begin
				$display("Timeout: no decoded write for a sound ROM byte");
				abort_run();
			end
			check_addr("sound ROM offset", off,
				u_irem_dl_top.u_cmd.offset[SND_ADDR_W-1:0]);
			snd_model[off] = data;
			written_q.push_back(off);
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin : main_seq
		logic [31:0] r;
		int          i;
		int          j;
		int          pulse_len;
		dl_addr_t    addr;
		dl_byte_t    v;

		rng_state      = 32'h1d4d0157;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		soft_reset     = 1'b0;
		snd_rom_addr   = '0;
		dip0_m         = '0;
		dip1_m         = '0;
		variant_m      = '0;
		p1_par         = 1'b0;
		p2_par         = 1'b0;
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;

		// Reset values
		check_bit("reset port1_req", 1'b0, port1_req);
		check_bit("reset port2_req", 1'b0, port2_req);
		check_byte("reset dip_sw0", 8'h00, dip_sw0);
		check_byte("reset dip_sw1", 8'h00, dip_sw1);
		check_byte("reset hw_variant", 8'h00, hw_variant);
		check_bit("reset landscape", 1'b1, landscape);
		check_bit("reset rotate_ccw", 1'b0, rotate_ccw);
		check_bit("reset rom_loaded", 1'b0, rom_loaded);
		check_bit("reset core_reset", 1'b1, core_reset);

		// DIP bytes where banks 2 and 3 must be ignored
		for (i = 0; i < 16; i++) begin
			r    = next_rand();
			addr = dl_addr_t'(r[1:0]);
			loader_write(DIP_INDEX, addr, r[15:8]);
			// Store not written yet
			check_byte("dip_sw0 early", dip0_m, dip_sw0);
			check_byte("dip_sw1 early", dip1_m, dip_sw1);
			if (addr == dl_addr_t'(0)) begin
				dip0_m = r[15:8];
			end else if (addr == dl_addr_t'(1)) begin
				dip1_m = r[15:8];
			end
			@(negedge clk_sys);
			check_byte("dip_sw0 write", dip0_m, dip_sw0);
			check_byte("dip_sw1 write", dip1_m, dip_sw1);
		end

		// Variant byte and orientation
		for (i = 0; i < 16; i++) begin
			r = next_rand();
			v = r[15:8];
			if (i == 4) begin
				v = VARIANT_PORTRAIT;
			end
			if (i == 9) begin
				v = VARIANT_PORTRAIT_CCW;
			end
			loader_write(VARIANT_INDEX, dl_addr_t'(r[31:16]), v);
			variant_m = v;
			@(negedge clk_sys);
			check_byte("hw_variant", variant_m, hw_variant);
			check_bit("landscape", !((variant_m == VARIANT_PORTRAIT) ||
				(variant_m == VARIANT_PORTRAIT_CCW)), landscape);
			check_bit("rotate_ccw", variant_m == VARIANT_PORTRAIT_CCW, rotate_ccw);
		end
		check_bit("config port1_req", 1'b0, port1_req);
		check_bit("config core_reset", 1'b1, core_reset);

		// ROM download starting with the sound region
		ioctl_download = 1'b1;
		ioctl_index    = ROM_INDEX;
		for (i = 0; i < 24; i++) begin
			r = next_rand();
			rom_write(SND_BASE + dl_addr_t'(r[15:0]), r[23:16]);
		end
		@(negedge clk_sys);
		check_bit("sound port1_req", p1_par, port1_req);
		check_bit("sound port2_req", p2_par, port2_req);

		// Mixed CPU, sound and graphics bytes
		for (i = 0; i < 40; i++) begin
			r = next_rand();
			case (r[1:0])
				2'd0: addr = dl_addr_t'(r[18:2]);
				2'd1: addr = SND_BASE + dl_addr_t'(r[17:2]);
				default: addr = GFX_BASE + dl_addr_t'(r[25:2]);
			endcase
			rom_write(addr, r[31:24]);
		end
		@(negedge clk_sys);
		check_bit("mixed port1_req", p1_par, port1_req);
		check_bit("mixed port2_req", p2_par, port2_req);
		check_bit("download core_reset", 1'b1, core_reset);

		// Read back with data one cycle after the address
		for (i = 0; i < written_q.size(); i++) begin
			snd_rom_addr = written_q[i];
			// Before the clock edge the port still holds the previous byte
			#1;
			if (i > 0) begin
				check_byte("sound ROM read latency", snd_model[written_q[i-1]],
					snd_rom_data);
			end
			@(negedge clk_sys);
			check_byte("sound ROM read", snd_model[written_q[i]], snd_rom_data);
		end

		// End of download releases the core after the hold time
		ioctl_download = 1'b0;
		for (i = 1; i <= LOAD_LAG + RESET_HOLD_CYCLES + 1; i++) begin
			@(negedge clk_sys);
			check_bit("rom_loaded after download", i >= LOAD_LAG, rom_loaded);
			check_bit("core_reset after download",
				i <= LOAD_LAG + RESET_HOLD_CYCLES, core_reset);
		end

		// Soft reset pulse
		repeat (3) @(negedge clk_sys);
		r          = next_rand();
		pulse_len  = 2 + int'(r[1:0]);
		soft_reset = 1'b1;
		for (j = 1; j <= pulse_len; j++) begin
			@(negedge clk_sys);
			check_bit("core_reset in soft reset", j >= 2, core_reset);
		end
		soft_reset = 1'b0;
		for (i = 1; i <= RESET_HOLD_CYCLES + 1; i++) begin
			@(negedge clk_sys);
			check_bit("core_reset after soft reset", i <= RESET_HOLD_CYCLES, core_reset);
			check_bit("rom_loaded after soft reset", 1'b1, rom_loaded);
		end

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
arcade_dl_pkg.sv
dl_cmd_if.sv
dl_decoder.sv
dl_store.sv
core_reset_seq.sv
irem_dl_top.sv
tb_irem_dl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_irem_dl -o tb_irem_dl &&
	./obj_dir/tb_irem_dl | tee /dev/stderr | grep -q "Test OK" ||
	exit 1
